// File: axi_rd_id_serialize.f
hdl/axi_ids_pkg.sv
hdl/axi_pipe_reg.sv
hdl/ar_id_demux.sv
hdl/axi_rd_serializer.sv
hdl/ar_rr_mux.sv
hdl/axi_rd_id_serialize.sv
tb/axi_rd_slave_model.sv
tb/tb_axi_rd_id_serialize.sv

// File: hdl/ar_id_demux.sv
// Slave-side splitter of the read ID serializer.
// Registers each AR and hands it to the slot picked by ID modulo the slot
// count; read data from the slots is merged back onto the slave port.
module ar_id_demux (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 slv_ar_valid_i,
  input  axi_ids_pkg::slv_id_t slv_ar_id_i,
  input  axi_ids_pkg::addr_t   slv_ar_addr_i,
  input  axi_ids_pkg::len_t    slv_ar_len_i,
  output logic                 slv_ar_ready_o,
  output logic                 slv_r_valid_o,
  output axi_ids_pkg::slv_id_t slv_r_id_o,
  output axi_ids_pkg::data_t   slv_r_data_o,
  output logic                 slv_r_last_o,
  input  logic                 slv_r_ready_i,
  output logic [axi_ids_pkg::NumSlots-1:0] slot_ar_valid_o,
  output axi_ids_pkg::slv_ar_t             slot_ar_o [axi_ids_pkg::NumSlots],
  input  logic [axi_ids_pkg::NumSlots-1:0] slot_ar_ready_i,
  input  logic [axi_ids_pkg::NumSlots-1:0] slot_r_valid_i,
  input  axi_ids_pkg::slv_id_t             slot_r_id_i [axi_ids_pkg::NumSlots],
  input  axi_ids_pkg::data_t               slot_r_data_i [axi_ids_pkg::NumSlots],
  input  logic [axi_ids_pkg::NumSlots-1:0] slot_r_last_i,
  output logic [axi_ids_pkg::NumSlots-1:0] slot_r_ready_o
);

  logic                   ar_valid;
  logic                   ar_ready;
  axi_ids_pkg::slv_ar_t   ar_q;
  axi_ids_pkg::slot_idx_t ar_slot;

  axi_pipe_reg #(
    .payload_t ( axi_ids_pkg::slv_ar_t )
  ) i_ar_reg (
    .clk_i       ( clk_i                                       ),
    .arst_n_i    ( arst_n_i                                    ),
    .in_valid_i  ( slv_ar_valid_i                              ),
    .in_data_i   ( {slv_ar_id_i, slv_ar_addr_i, slv_ar_len_i} ),
    .in_ready_o  ( slv_ar_ready_o                              ),
    .out_valid_o ( ar_valid                                    ),
    .out_data_o  ( ar_q                                        ),
    .out_ready_i ( ar_ready                                    )
  );

  // Slot index is the low part of the slave ID
  assign ar_slot  = axi_ids_pkg::slot_idx_t'(
                      ar_q[axi_ids_pkg::SlvArIdLsb +: axi_ids_pkg::SlvIdWidth] %
                      axi_ids_pkg::NumSlots);
  assign ar_ready = slot_ar_ready_i[ar_slot];

  for (genvar i = 0; i < axi_ids_pkg::NumSlots; i++) begin : gen_slot_ar
    assign slot_ar_valid_o[i] = ar_valid & (ar_slot == axi_ids_pkg::slot_idx_t'(i));
    assign slot_ar_o[i]       = ar_q;
  end

  // The mux routes each beat to one slot only, so an OR of masked beats suffices
  always_comb begin
    slv_r_valid_o = 1'b0;
    slv_r_id_o    = '0;
    slv_r_data_o  = '0;
    slv_r_last_o  = 1'b0;
    for (int i = 0; i < axi_ids_pkg::NumSlots; i++) begin
      if (slot_r_valid_i[i]) begin
        slv_r_valid_o = 1'b1;
        slv_r_id_o    = slv_r_id_o | slot_r_id_i[i];
        slv_r_data_o  = slv_r_data_o | slot_r_data_i[i];
        slv_r_last_o  = slv_r_last_o | slot_r_last_i[i];
      end
    end
  end

  assign slot_r_ready_o = {axi_ids_pkg::NumSlots{slv_r_ready_i}};

endmodule

// File: hdl/ar_rr_mux.sv
// Master-side merger of the read ID serializer.
// Round-robin arbitration over the slot ARs into a registered master AR,
// with the slot index as master ID. Read data goes back by master ID.
module ar_rr_mux (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic [axi_ids_pkg::NumSlots-1:0] slot_ar_valid_i,
  input  axi_ids_pkg::addr_t               slot_ar_addr_i [axi_ids_pkg::NumSlots],
  input  axi_ids_pkg::len_t                slot_ar_len_i [axi_ids_pkg::NumSlots],
  output logic [axi_ids_pkg::NumSlots-1:0] slot_ar_ready_o,
  output logic                             mst_ar_valid_o,
  output axi_ids_pkg::mst_id_t             mst_ar_id_o,
  output axi_ids_pkg::addr_t               mst_ar_addr_o,
  output axi_ids_pkg::len_t                mst_ar_len_o,
  input  logic                             mst_ar_ready_i,
  input  logic                             mst_r_valid_i,
  input  axi_ids_pkg::mst_id_t             mst_r_id_i,
  input  axi_ids_pkg::data_t               mst_r_data_i,
  input  logic                             mst_r_last_i,
  output logic                             mst_r_ready_o,
  output logic [axi_ids_pkg::NumSlots-1:0] slot_r_valid_o,
  output axi_ids_pkg::data_t               slot_r_data_o [axi_ids_pkg::NumSlots],
  output logic [axi_ids_pkg::NumSlots-1:0] slot_r_last_o,
  input  logic [axi_ids_pkg::NumSlots-1:0] slot_r_ready_i
);

  axi_ids_pkg::slot_idx_t rr_q;
  axi_ids_pkg::slot_idx_t grant;
  logic                   any_req;
  logic                   arb_ready;
  axi_ids_pkg::mst_ar_t   mst_ar;

  // First requester at or after the pointer; walk backwards so the nearest wins
  always_comb begin
    axi_ids_pkg::slot_idx_t idx;
    grant   = rr_q;
    any_req = 1'b0;
    for (int k = axi_ids_pkg::NumSlots - 1; k >= 0; k--) begin
      idx = rr_q + axi_ids_pkg::slot_idx_t'(k);
      if (slot_ar_valid_i[idx]) begin
        grant   = idx;
        any_req = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q <= '0;
    end else if (any_req && arb_ready) begin
      rr_q <= grant + 1'b1;
    end
  end

  for (genvar i = 0; i < axi_ids_pkg::NumSlots; i++) begin : gen_slot
    assign slot_ar_ready_o[i] = arb_ready & (grant == axi_ids_pkg::slot_idx_t'(i));
    assign slot_r_valid_o[i]  = mst_r_valid_i & (mst_r_id_i == axi_ids_pkg::mst_id_t'(i));
    assign slot_r_data_o[i]   = mst_r_data_i;
    assign slot_r_last_o[i]   = mst_r_last_i;
  end

  axi_pipe_reg #(
    .payload_t ( axi_ids_pkg::mst_ar_t )
  ) i_ar_reg (
    .clk_i       ( clk_i                                     ),
    .arst_n_i    ( arst_n_i                                  ),
    .in_valid_i  ( any_req                                   ),
    .in_data_i   ( {axi_ids_pkg::mst_id_t'(grant), slot_ar_addr_i[grant],
                    slot_ar_len_i[grant]}                    ),
    .in_ready_o  ( arb_ready                                 ),
    .out_valid_o ( mst_ar_valid_o                            ),
    .out_data_o  ( mst_ar                                    ),
    .out_ready_i ( mst_ar_ready_i                            )
  );

  assign {mst_ar_id_o, mst_ar_addr_o, mst_ar_len_o} = mst_ar;
  assign mst_r_ready_o = slot_r_ready_i[mst_r_id_i];

endmodule

// File: hdl/axi_ids_pkg.sv
// Widths, counts and payload types shared by the AXI read ID serializer.
// Every design file refers to these through scoped names.
package axi_ids_pkg;

  // ID widths at the slave and master ports
  localparam int unsigned SlvIdWidth = 4;
  localparam int unsigned MstIdWidth = 2;

  // Serializer slots, one per master ID
  localparam int unsigned NumSlots     = 4;
  localparam int unsigned SlotIdxWidth = $clog2(NumSlots);

  // Reads in flight per slot and the counter that tracks them
  localparam int unsigned MaxTxnsPerId = 4;
  localparam int unsigned CntWidth     = $clog2(MaxTxnsPerId + 1);

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LenWidth  = 8;

  // Lowest bit of the ID field in a packed slave AR
  localparam int unsigned SlvArIdLsb = AddrWidth + LenWidth;

  typedef logic [SlvIdWidth-1:0] slv_id_t;
  typedef logic [MstIdWidth-1:0] mst_id_t;
  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [DataWidth-1:0]  data_t;
  typedef logic [LenWidth-1:0]   len_t;

  typedef logic [SlotIdxWidth-1:0] slot_idx_t;
  typedef logic [CntWidth-1:0]     cnt_t;

  // Packed AR payloads: ID in the top bits, then address, then burst length
  typedef logic [SlvIdWidth+AddrWidth+LenWidth-1:0] slv_ar_t;
  typedef logic [MstIdWidth+AddrWidth+LenWidth-1:0] mst_ar_t;

endpackage

// File: hdl/axi_pipe_reg.sv
// Single-entry valid/ready pipeline register for any payload type.
// Loads a new item in the same cycle the held one leaves, so a stream
// passes at full rate with one cycle of latency.
module axi_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  logic     valid_q;
  logic     run_q;
  logic     load;
  payload_t data_q;

  // Not ready in the first cycle after reset release
  assign in_ready_o = run_q & (~valid_q | out_ready_i);
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      run_q   <= 1'b0;
    end else begin
      run_q <= 1'b1;
      // Empty or draining this cycle, so take whatever is offered
      if (in_ready_o) begin
        valid_q <= in_valid_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

// File: hdl/axi_rd_id_serialize.sv
// Read-only AXI ID serializer, top level.
// Narrows 4-bit slave IDs to 2-bit master IDs: demux by ID into serializer
// slots, round-robin merge onto the master port, IDs restored on the way back.
module axi_rd_id_serialize (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 slv_ar_valid_i,
  input  axi_ids_pkg::slv_id_t slv_ar_id_i,
  input  axi_ids_pkg::addr_t   slv_ar_addr_i,
  input  axi_ids_pkg::len_t    slv_ar_len_i,
  output logic                 slv_ar_ready_o,
  output logic                 slv_r_valid_o,
  output axi_ids_pkg::slv_id_t slv_r_id_o,
  output axi_ids_pkg::data_t   slv_r_data_o,
  output logic                 slv_r_last_o,
  input  logic                 slv_r_ready_i,
  output logic                 mst_ar_valid_o,
  output axi_ids_pkg::mst_id_t mst_ar_id_o,
  output axi_ids_pkg::addr_t   mst_ar_addr_o,
  output axi_ids_pkg::len_t    mst_ar_len_o,
  input  logic                 mst_ar_ready_i,
  input  logic                 mst_r_valid_i,
  input  axi_ids_pkg::mst_id_t mst_r_id_i,
  input  axi_ids_pkg::data_t   mst_r_data_i,
  input  logic                 mst_r_last_i,
  output logic                 mst_r_ready_o
);

  // Demux to slots
  logic [axi_ids_pkg::NumSlots-1:0] dmx_ar_valid, dmx_ar_ready;
  axi_ids_pkg::slv_ar_t             dmx_ar [axi_ids_pkg::NumSlots];
  logic [axi_ids_pkg::NumSlots-1:0] dmx_r_valid, dmx_r_last, dmx_r_ready;
  axi_ids_pkg::slv_id_t             dmx_r_id [axi_ids_pkg::NumSlots];
  axi_ids_pkg::data_t               dmx_r_data [axi_ids_pkg::NumSlots];
  // Slots to mux, ID already stripped
  logic [axi_ids_pkg::NumSlots-1:0] mux_ar_valid, mux_ar_ready;
  axi_ids_pkg::addr_t               mux_ar_addr [axi_ids_pkg::NumSlots];
  axi_ids_pkg::len_t                mux_ar_len [axi_ids_pkg::NumSlots];
  logic [axi_ids_pkg::NumSlots-1:0] mux_r_valid, mux_r_last, mux_r_ready;
  axi_ids_pkg::data_t               mux_r_data [axi_ids_pkg::NumSlots];

  ar_id_demux i_demux (
    .clk_i, .arst_n_i,
    .slv_ar_valid_i, .slv_ar_id_i, .slv_ar_addr_i, .slv_ar_len_i, .slv_ar_ready_o,
    .slv_r_valid_o, .slv_r_id_o, .slv_r_data_o, .slv_r_last_o, .slv_r_ready_i,
    .slot_ar_valid_o ( dmx_ar_valid ), .slot_ar_o ( dmx_ar ), .slot_ar_ready_i ( dmx_ar_ready ),
    .slot_r_valid_i  ( dmx_r_valid  ), .slot_r_id_i   ( dmx_r_id   ),
    .slot_r_data_i   ( dmx_r_data   ), .slot_r_last_i ( dmx_r_last ),
    .slot_r_ready_o  ( dmx_r_ready  )
  );

  for (genvar i = 0; i < axi_ids_pkg::NumSlots; i++) begin : gen_slots
    axi_rd_serializer i_ser (
      .clk_i, .arst_n_i,
      .in_ar_valid_i  ( dmx_ar_valid[i] ), .in_ar_i ( dmx_ar[i] ),
      .in_ar_ready_o  ( dmx_ar_ready[i] ),
      .out_ar_valid_o ( mux_ar_valid[i] ), .out_ar_addr_o ( mux_ar_addr[i] ),
      .out_ar_len_o   ( mux_ar_len[i]   ), .out_ar_ready_i ( mux_ar_ready[i] ),
      .in_r_valid_i   ( mux_r_valid[i]  ), .in_r_data_i ( mux_r_data[i] ),
      .in_r_last_i    ( mux_r_last[i]   ), .in_r_ready_o ( mux_r_ready[i] ),
      .out_r_valid_o  ( dmx_r_valid[i]  ), .out_r_id_o ( dmx_r_id[i] ),
      .out_r_data_o   ( dmx_r_data[i]   ), .out_r_last_o ( dmx_r_last[i] ),
      .out_r_ready_i  ( dmx_r_ready[i]  )
    );
  end

  ar_rr_mux i_mux (
    .clk_i, .arst_n_i,
    .slot_ar_valid_i ( mux_ar_valid ), .slot_ar_addr_i ( mux_ar_addr ),
    .slot_ar_len_i   ( mux_ar_len   ), .slot_ar_ready_o ( mux_ar_ready ),
    .mst_ar_valid_o, .mst_ar_id_o, .mst_ar_addr_o, .mst_ar_len_o, .mst_ar_ready_i,
    .mst_r_valid_i, .mst_r_id_i, .mst_r_data_i, .mst_r_last_i, .mst_r_ready_o,
    .slot_r_valid_o  ( mux_r_valid  ), .slot_r_data_o ( mux_r_data ),
    .slot_r_last_o   ( mux_r_last   ), .slot_r_ready_i ( mux_r_ready )
  );

endmodule

// File: hdl/axi_rd_serializer.sv
// One serializer slot. Reads sharing a slave ID go out back to back;
// a read with another ID waits until every read in flight has finished.
// The ID is dropped towards the mux and put back on returning read data.
module axi_rd_serializer (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 in_ar_valid_i,
  input  axi_ids_pkg::slv_ar_t in_ar_i,
  output logic                 in_ar_ready_o,
  output logic                 out_ar_valid_o,
  output axi_ids_pkg::addr_t   out_ar_addr_o,
  output axi_ids_pkg::len_t    out_ar_len_o,
  input  logic                 out_ar_ready_i,
  input  logic                 in_r_valid_i,
  input  axi_ids_pkg::data_t   in_r_data_i,
  input  logic                 in_r_last_i,
  output logic                 in_r_ready_o,
  output logic                 out_r_valid_o,
  output axi_ids_pkg::slv_id_t out_r_id_o,
  output axi_ids_pkg::data_t   out_r_data_o,
  output logic                 out_r_last_o,
  input  logic                 out_r_ready_i
);

  axi_ids_pkg::slv_id_t ar_id;
  axi_ids_pkg::slv_id_t id_q;
  axi_ids_pkg::cnt_t    cnt_q;
  logic                 ar_pass;
  logic                 ar_done;
  logic                 r_done;

  assign {ar_id, out_ar_addr_o, out_ar_len_o} = in_ar_i;

  // Any ID may enter an empty slot, a matching one only below the limit
  assign ar_pass = (cnt_q == '0) ||
                   ((ar_id == id_q) &&
                    (cnt_q < axi_ids_pkg::cnt_t'(axi_ids_pkg::MaxTxnsPerId)));

  assign out_ar_valid_o = in_ar_valid_i & ar_pass;
  assign in_ar_ready_o  = out_ar_ready_i & ar_pass;

  assign ar_done = out_ar_valid_o & out_ar_ready_i;
  // A read counts as finished on its last beat
  assign r_done  = in_r_valid_i & in_r_ready_o & in_r_last_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_q  <= '0;
      cnt_q <= '0;
    end else begin
      if (ar_done) begin
        id_q <= ar_id;
      end
      if (ar_done && !r_done) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (r_done && !ar_done) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // id_q stays put while reads are in flight, so every beat gets the right ID
  assign out_r_valid_o = in_r_valid_i;
  assign out_r_id_o    = id_q;
  assign out_r_data_o  = in_r_data_i;
  assign out_r_last_o  = in_r_last_i;
  assign in_r_ready_o  = out_r_ready_i;

endmodule

// File: tb/axi_rd_slave_model.sv
// In-order AXI read slave for the ID serializer testbench.
// Answers each AR with len+1 beats of address plus beat index. Gap inputs
// throttle ready and valid, hold_i keeps R back until released.
module axi_rd_slave_model (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 hold_i,
  input  logic                 ar_gap_i,
  input  logic                 r_gap_i,
  input  logic                 ar_valid_i,
  input  axi_ids_pkg::mst_id_t ar_id_i,
  input  axi_ids_pkg::addr_t   ar_addr_i,
  input  axi_ids_pkg::len_t    ar_len_i,
  output logic                 ar_ready_o,
  output logic                 r_valid_o,
  output axi_ids_pkg::mst_id_t r_id_o,
  output axi_ids_pkg::data_t   r_data_o,
  output logic                 r_last_o,
  input  logic                 r_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Accepted ARs in arrival order and the end times of finished reads
  axi_ids_pkg::mst_id_t log_id [32];
  axi_ids_pkg::addr_t   log_addr [32];
  axi_ids_pkg::len_t    log_len [32];
  time                  ar_time [32];
  time                  last_time [32];
  int                   ar_cnt;
  int                   done_cnt;
  int                   beat;
  logic                 r_taken;

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ar_cnt   = 0;
      done_cnt = 0;
      beat     = 0;
      r_taken  = 1'b0;
    end else begin
      r_taken = r_valid_o & r_ready_i;
      if (ar_valid_i && ar_ready_o) begin
        log_id[ar_cnt]   = ar_id_i;
        log_addr[ar_cnt] = ar_addr_i;
        log_len[ar_cnt]  = ar_len_i;
        ar_time[ar_cnt]  = $time;
        ar_cnt++;
      end
      if (r_taken) begin
        beat++;
        if (r_last_o) begin
          last_time[done_cnt] = $time;
          done_cnt++;
          beat = 0;
        end
      end
    end
  end

  // Outputs change on the falling edge, a beat on offer stays until taken
  always @(negedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_id_o     <= '0;
      r_data_o   <= '0;
      r_last_o   <= 1'b0;
    end else begin
      ar_ready_o <= ~ar_gap_i;
      if (!r_valid_o || r_taken) begin
        r_valid_o <= (done_cnt < ar_cnt) && !hold_i && !r_gap_i;
        r_id_o    <= log_id[done_cnt];
        r_data_o  <= axi_ids_pkg::data_t'(log_addr[done_cnt]) + axi_ids_pkg::data_t'(beat);
        r_last_o  <= (beat == int'(log_len[done_cnt]));
      end
    end
  end

endmodule

// File: tb/tb_axi_rd_id_serialize.sv
// Directed testbench for the read-only AXI ID serializer.
// Sends slave-port reads, answers them with an in-order slave model and
// checks master IDs, restored slave IDs, read data and read ordering.
module tb_axi_rd_id_serialize;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int Timeout = 300;

  logic clk_i, arst_n_i, hold, ar_gap, r_gap;
  logic slv_ar_valid_i, slv_ar_ready_o, slv_r_valid_o, slv_r_last_o, slv_r_ready_i;
  logic mst_ar_valid_o, mst_ar_ready_i, mst_r_valid_i, mst_r_last_i, mst_r_ready_o;
  axi_ids_pkg::slv_id_t slv_ar_id_i, slv_r_id_o;
  axi_ids_pkg::mst_id_t mst_ar_id_o, mst_r_id_i;
  axi_ids_pkg::addr_t   slv_ar_addr_i, mst_ar_addr_o;
  axi_ids_pkg::len_t    slv_ar_len_i, mst_ar_len_o;
  axi_ids_pkg::data_t   slv_r_data_o, mst_r_data_i;
  logic [15:0]          lfsr_q;
  int                   errors, timeouts, ar_sent, beat_cnt;
  // Slave-port R beats in arrival order
  axi_ids_pkg::slv_id_t beat_id [64];
  axi_ids_pkg::data_t   beat_data [64];
  logic                 beat_last [64];

  axi_rd_id_serialize dut_i (.*);

  axi_rd_slave_model slave_model (
    .clk_i, .arst_n_i, .hold_i (hold), .ar_gap_i (ar_gap), .r_gap_i (r_gap),
    .ar_valid_i (mst_ar_valid_o), .ar_id_i (mst_ar_id_o), .ar_addr_i (mst_ar_addr_o),
    .ar_len_i (mst_ar_len_o), .ar_ready_o (mst_ar_ready_i),
    .r_valid_o (mst_r_valid_i), .r_id_o (mst_r_id_i), .r_data_o (mst_r_data_i),
    .r_last_o (mst_r_last_i), .r_ready_i (mst_r_ready_o)
  );

  always #20 clk_i = ~clk_i;

  // 16-bit Fibonacci LFSR over taps 16 14 13 11 that steps once per random bit
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  // Random gaps on both sides of the DUT
  always @(negedge clk_i) begin
    ar_gap        <= lfsr_bit();
    r_gap         <= lfsr_bit();
    slv_r_ready_i <= lfsr_bit();
  end

  always @(posedge clk_i) begin
    if (slv_ar_valid_i && slv_ar_ready_o) begin
      ar_sent++;
    end
    if (slv_r_valid_o && slv_r_ready_i) begin
      beat_id[beat_cnt]   = slv_r_id_o;
      beat_data[beat_cnt] = slv_r_data_o;
      beat_last[beat_cnt] = slv_r_last_o;
      beat_cnt++;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  // Offer one read on the slave port and hold it until accepted
  task automatic send_ar(input axi_ids_pkg::slv_id_t id, input axi_ids_pkg::addr_t addr,
                         input axi_ids_pkg::len_t len);
    int start;
    int t;
    start          = ar_sent;
    t              = 0;
    slv_ar_valid_i = 1'b1;
    slv_ar_id_i    = id;
    slv_ar_addr_i  = addr;
    slv_ar_len_i   = len;
    while (ar_sent == start && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    slv_ar_valid_i = 1'b0;
    if (ar_sent == start) begin
      timeouts++;
      $display("Timeout: slave port never accepted the read with ID %0d", id);
    end
  endtask

  task automatic wait_counts(input int ars, input int beats);
    int t;
    t = 0;
    while ((slave_model.ar_cnt < ars || beat_cnt < beats) && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    if (slave_model.ar_cnt < ars || beat_cnt < beats) begin
      timeouts++;
      $display("Timeout: waited for %0d master reads and %0d read beats", ars, beats);
    end
  endtask

  // Master port has to stay at n reads over a window
  task automatic expect_ar_count(input int n);
    repeat (24) @(negedge clk_i);
    if (slave_model.ar_cnt != n)
      report_mismatch("master AR count", slave_model.ar_cnt, n);
  endtask

  task automatic check_ar(input int idx, input axi_ids_pkg::mst_id_t id,
                          input axi_ids_pkg::addr_t addr, input axi_ids_pkg::len_t len);
    if (slave_model.log_id[idx] != id)
      report_mismatch("mst_ar_id_o", slave_model.log_id[idx], id);
    if (slave_model.log_addr[idx] != addr)
      report_mismatch("mst_ar_addr_o", slave_model.log_addr[idx], addr);
    if (slave_model.log_len[idx] != len)
      report_mismatch("mst_ar_len_o", slave_model.log_len[idx], len);
  endtask

  // Beats from index first on carry the slave ID and address plus beat index
  task automatic check_read(input int first, input axi_ids_pkg::slv_id_t id,
                            input axi_ids_pkg::addr_t addr, input axi_ids_pkg::len_t len);
    int n;
    for (int b = 0; b <= int'(len); b++) begin
      n = first + b;
      if (beat_id[n] != id)
        report_mismatch("slv_r_id_o", beat_id[n], id);
      if (beat_data[n] != 32'(addr) + b)
        report_mismatch("slv_r_data_o", beat_data[n], 32'(addr) + b);
      if (beat_last[n] != (b == int'(len)))
        report_mismatch("slv_r_last_o", beat_last[n], b == int'(len));
    end
  endtask

  task automatic check_after_last(input int ar_idx, input int done_idx);
    if (slave_model.ar_time[ar_idx] <= slave_model.last_time[done_idx]) begin
      errors++;
      $display("A held read reached the master port before the earlier read finished");
    end
  endtask

  task automatic test_reset_state();
    if (slv_ar_ready_o !== 1'b0)
      report_mismatch("slv_ar_ready_o", slv_ar_ready_o, 0);
    if (slv_r_valid_o !== 1'b0)
      report_mismatch("slv_r_valid_o", slv_r_valid_o, 0);
    if (mst_ar_valid_o !== 1'b0)
      report_mismatch("mst_ar_valid_o", mst_ar_valid_o, 0);
  endtask

  task automatic test_single_read();
    int a0;
    int b0;
    a0 = slave_model.ar_cnt;
    b0 = beat_cnt;
    send_ar(4'd6, 16'h1000, 8'd3);
    wait_counts(a0 + 1, b0 + 4);
    check_ar(a0, 2'd2, 16'h1000, 8'd3);
    check_read(b0, 4'd6, 16'h1000, 8'd3);
  endtask

  task automatic test_same_id();
    int a0;
    int b0;
    a0 = slave_model.ar_cnt;
    b0 = beat_cnt;
    hold <= 1'b1;
    send_ar(4'd3, 16'h2000, 8'd1);
    send_ar(4'd3, 16'h2100, 8'd0);
    send_ar(4'd3, 16'h2200, 8'd2);
    wait_counts(a0 + 3, b0);
    if (beat_cnt != b0)
      report_mismatch("read beats while held", beat_cnt, b0);
    check_ar(a0, 2'd3, 16'h2000, 8'd1);
    check_ar(a0 + 1, 2'd3, 16'h2100, 8'd0);
    check_ar(a0 + 2, 2'd3, 16'h2200, 8'd2);
    hold <= 1'b0;
    wait_counts(a0 + 3, b0 + 6);
    check_read(b0, 4'd3, 16'h2000, 8'd1);
    check_read(b0 + 2, 4'd3, 16'h2100, 8'd0);
    check_read(b0 + 3, 4'd3, 16'h2200, 8'd2);
  endtask

  // IDs 1 and 5 share slot 1, so the second waits for the first to finish
  task automatic test_serialize();
    int a0;
    int b0;
    int d0;
    a0 = slave_model.ar_cnt;
    b0 = beat_cnt;
    d0 = slave_model.done_cnt;
    hold <= 1'b1;
    send_ar(4'd1, 16'h3000, 8'd1);
    send_ar(4'd5, 16'h3100, 8'd1);
    wait_counts(a0 + 1, b0);
    expect_ar_count(a0 + 1);
    hold <= 1'b0;
    wait_counts(a0 + 2, b0 + 4);
    check_ar(a0, 2'd1, 16'h3000, 8'd1);
    check_ar(a0 + 1, 2'd1, 16'h3100, 8'd1);
    check_after_last(a0 + 1, d0);
    check_read(b0, 4'd1, 16'h3000, 8'd1);
    check_read(b0 + 2, 4'd5, 16'h3100, 8'd1);
  endtask

  task automatic test_two_slots();
    int a0;
    int b0;
    a0 = slave_model.ar_cnt;
    b0 = beat_cnt;
    hold <= 1'b1;
    send_ar(4'd2, 16'h4000, 8'd0);
    send_ar(4'd3, 16'h4100, 8'd1);
    wait_counts(a0 + 2, b0);
    check_ar(a0, 2'd2, 16'h4000, 8'd0);
    check_ar(a0 + 1, 2'd3, 16'h4100, 8'd1);
    hold <= 1'b0;
    wait_counts(a0 + 2, b0 + 3);
    check_read(b0, 4'd2, 16'h4000, 8'd0);
    check_read(b0 + 1, 4'd3, 16'h4100, 8'd1);
  endtask

  // Five reads with one ID while only four may be in flight
  task automatic test_limit();
    int a0;
    int b0;
    int d0;
    a0 = slave_model.ar_cnt;
    b0 = beat_cnt;
    d0 = slave_model.done_cnt;
    hold <= 1'b1;
    for (int k = 0; k < 5; k++) begin
      send_ar(4'd0, axi_ids_pkg::addr_t'(16'h5000 + k * 256), 8'd1);
    end
    wait_counts(a0 + 4, b0);
    expect_ar_count(a0 + 4);
    hold <= 1'b0;
    wait_counts(a0 + 5, b0 + 10);
    check_after_last(a0 + 4, d0);
    for (int k = 0; k < 5; k++) begin
      check_ar(a0 + k, 2'd0, axi_ids_pkg::addr_t'(16'h5000 + k * 256), 8'd1);
      check_read(b0 + 2 * k, 4'd0, axi_ids_pkg::addr_t'(16'h5000 + k * 256), 8'd1);
    end
  endtask

  initial begin
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    hold           = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_r_ready_i  = 1'b0;
    lfsr_q         = 16'd48493;
    errors         = 0;
    timeouts       = 0;
    ar_sent        = 0;
    beat_cnt       = 0;
    repeat (3) @(negedge clk_i);
    test_reset_state();
    arst_n_i = 1'b1;
    test_single_read();
    test_same_id();
    test_serialize();
    test_two_slots();
    test_limit();
    $display("Check failures: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
